/* hdl/snitch_offload_pkg.sv */
// ------------------------------------------------------------
// Shared widths, types and SSR register map for the offload
// path. Import it wherever these definitions are needed.
// ------------------------------------------------------------
`default_nettype none

package snitch_offload_pkg;

  // Widths
  localparam int unsigned data_w       = 32;
  localparam int unsigned id_w         = 5;
  localparam int unsigned imm_w        = 12;

  // SSR register map
  localparam int unsigned num_ssrs     = 2;
  localparam int unsigned num_ssr_regs = 4;
  localparam int unsigned ssr_sel_w    = $clog2(num_ssrs);
  localparam int unsigned reg_sel_w    = $clog2(num_ssr_regs);

  typedef logic [data_w-1:0] data_t;
  typedef logic [id_w-1:0]   id_t;
  typedef logic [imm_w-1:0]  imm_t;

  // SSR index in the upper 5 bits, register index in the lower 7
  typedef struct packed {
    logic [4:0] ssr;
    logic [6:0] idx;
  } cfg_word_t;

  typedef enum logic {TARGET_EXT, TARGET_SSR} acc_target_e;

  typedef enum logic [1:0] {SCFGR, SCFGW, SCFGRI, SCFGWI} ssr_op_e;

  typedef enum logic [reg_sel_w-1:0] {
    REG_STATUS,
    REG_REPEAT,
    REG_BOUND,
    REG_STRIDE
  } ssr_reg_e;

  typedef enum logic {CFG_IDLE, CFG_RESP} cfg_state_e;

endpackage

`default_nettype wire

/* hdl/ssr_cfg_if.sv */
// ------------------------------------------------------------
// Access port from the SSR config FSM into the register bank.
// Read data follows word combinationally.
// ------------------------------------------------------------
`default_nettype none

interface ssr_cfg_if import snitch_offload_pkg::*; ();

  logic      valid;
  logic      write;
  cfg_word_t word;
  data_t     wdata;
  data_t     rdata;

  modport ctrl (output valid, write, word, wdata, input rdata);
  modport bank (input valid, write, word, wdata, output rdata);

endinterface

`default_nettype wire

/* hdl/acc_rsp_if.sv */
// ------------------------------------------------------------
// One offload response stream with valid/ready handshake,
// from a responder into the response arbiter.
// ------------------------------------------------------------
`default_nettype none

interface acc_rsp_if import snitch_offload_pkg::*; ();

  logic  valid;
  logic  ready;
  id_t   id;
  data_t data;
  logic  error;

  modport src  (output valid, id, data, error, input ready);
  modport sink (input valid, id, data, error, output ready);

endinterface

`default_nettype wire

/* hdl/offload_router.sv */
// ------------------------------------------------------------
// Steers offload requests to the external port or the SSR
// config unit, and decodes the four SSR config operations.
// ------------------------------------------------------------
`default_nettype none

module offload_router import snitch_offload_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  acc_target_e req_target_i,
  input  ssr_op_e     req_op_i,
  input  imm_t        req_imm_i,
  input  id_t         req_id_i,
  input  data_t       req_arga_i,
  input  data_t       req_argb_i,
  output logic        ext_qvalid_o,
  input  logic        ext_qready_i,
  output logic        ssr_qvalid_o,
  input  logic        ssr_qready_i,
  output logic        ssr_write_o,
  output cfg_word_t   ssr_word_o,
  output data_t       ssr_wdata_o,
  output id_t         ssr_id_o
);

  imm_t addr;

  // ----------------------------------------------------------
  // Target demux
  // ----------------------------------------------------------
  assign ext_qvalid_o = req_valid_i && (req_target_i == TARGET_EXT);
  assign ssr_qvalid_o = req_valid_i && (req_target_i == TARGET_SSR);
  assign req_ready_o  = (req_target_i == TARGET_SSR) ? ssr_qready_i : ext_qready_i;

  // ----------------------------------------------------------
  // SSR config decode
  // ----------------------------------------------------------
  always_comb begin
    addr        = req_argb_i[imm_w-1:0];
    ssr_write_o = 1'b0;
    case (req_op_i)
      SCFGRI: addr = req_imm_i;
      SCFGWI: begin
        addr        = req_imm_i;
        ssr_write_o = 1'b1;
      end
      SCFGW:  ssr_write_o = 1'b1;
      default: ;
    endcase
  end

  // Low address bits pick the SSR, high bits the register
  assign ssr_word_o  = '{ssr: addr[4:0], idx: addr[11:5]};
  assign ssr_wdata_o = req_arga_i;
  // Id 0 keeps the core from writing anything back
  assign ssr_id_o    = ssr_write_o ? '0 : req_id_i;

  // A stalled request keeps its target and payload
  a_req_held : assert property (
    @(posedge clk_i) disable iff (rst_ni)
    req_valid_i && !req_ready_o |=>
      req_valid_i && $stable(req_target_i) && $stable(req_op_i) && $stable(req_id_i)
  );

endmodule

`default_nettype wire

/* hdl/ssr_cfg_fsm.sv */
// ------------------------------------------------------------
// SSR config request handler. Takes one request at a time,
// accesses the bank and holds the response until it is taken.
// ------------------------------------------------------------
`default_nettype none

module ssr_cfg_fsm import snitch_offload_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  logic      req_write_i,
  input  cfg_word_t req_word_i,
  input  data_t     req_wdata_i,
  input  id_t       req_id_i,
  ssr_cfg_if.ctrl   cfg,
  acc_rsp_if.src    rsp
);

  cfg_state_e state_q;
  logic       accept;
  id_t        id_q;
  data_t      data_q;

  assign req_ready_o = (state_q == CFG_IDLE);
  assign accept      = req_valid_i && req_ready_o;

  // Bank access happens in the accepting cycle
  assign cfg.valid = accept;
  assign cfg.write = req_write_i;
  assign cfg.word  = req_word_i;
  assign cfg.wdata = req_wdata_i;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      state_q <= CFG_IDLE;
    end else begin
      case (state_q)
        CFG_IDLE: if (accept) state_q <= CFG_RESP;
        CFG_RESP: if (rsp.ready) state_q <= CFG_IDLE;
        default:  state_q <= CFG_IDLE;
      endcase
    end
  end

  // Read data is the word before the write lands
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q   <= req_id_i;
      data_q <= cfg.rdata;
    end
  end

  assign rsp.valid = (state_q == CFG_RESP);
  assign rsp.id    = id_q;
  assign rsp.data  = data_q;
  assign rsp.error = 1'b0;

  // Write responses carry id 0 so the core writes nothing back
  a_write_id_zero : assert property (
    @(posedge clk_i) disable iff (rst_ni)
    accept && req_write_i |=> rsp.id == '0
  );

endmodule

`default_nettype wire

/* hdl/ssr_cfg_regs.sv */
// ------------------------------------------------------------
// Per-SSR configuration words. Mapped words are read and
// written through the config port; others read as zero.
// ------------------------------------------------------------
`default_nettype none

module ssr_cfg_regs import snitch_offload_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  ssr_cfg_if.bank cfg
);

  data_t [num_ssrs-1:0][num_ssr_regs-1:0] words_q;

  logic [ssr_sel_w-1:0] ssr_sel;
  ssr_reg_e             reg_sel;
  logic                 mapped;

  // ----------------------------------------------------------
  // Word decode
  // ----------------------------------------------------------
  assign ssr_sel = cfg.word.ssr[ssr_sel_w-1:0];
  assign reg_sel = ssr_reg_e'(cfg.word.idx[reg_sel_w-1:0]);
  assign mapped  = (cfg.word.ssr < 5'(num_ssrs)) &&
                   (cfg.word.idx < 7'(num_ssr_regs));

  assign cfg.rdata = mapped ? words_q[ssr_sel][reg_sel] : '0;

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      words_q <= '0;
    end else if (cfg.valid && cfg.write && mapped) begin
      words_q[ssr_sel][reg_sel] <= cfg.wdata;
    end
  end

endmodule

`default_nettype wire

/* hdl/offload_rsp_arbiter.sv */
// ------------------------------------------------------------
// Round-robin merge of the external and SSR response streams
// into the single response stream towards the core.
// ------------------------------------------------------------
`default_nettype none

module offload_rsp_arbiter import snitch_offload_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  acc_rsp_if.sink    ext,
  acc_rsp_if.sink    ssr,
  output logic       rsp_valid_o,
  input  logic       rsp_ready_i,
  output id_t        rsp_id_o,
  output data_t      rsp_data_o,
  output logic       rsp_error_o
);

  // Set when the SSR stream won the last transfer
  logic last_ssr_q;
  logic grant_ssr;

  // On a tie the source that lost last time goes first
  assign grant_ssr = ssr.valid && (!ext.valid || !last_ssr_q);

  assign rsp_valid_o = ext.valid || ssr.valid;
  assign rsp_id_o    = grant_ssr ? ssr.id    : ext.id;
  assign rsp_data_o  = grant_ssr ? ssr.data  : ext.data;
  assign rsp_error_o = grant_ssr ? ssr.error : ext.error;

  assign ssr.ready = rsp_ready_i && grant_ssr;
  assign ext.ready = rsp_ready_i && !grant_ssr;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      last_ssr_q <= 1'b0;
    end else if (rsp_valid_o && rsp_ready_i) begin
      last_ssr_q <= grant_ssr;
    end
  end

  // The external source holds its response until it is taken
  a_ext_stable : assert property (
    @(posedge clk_i) disable iff (rst_ni)
    ext.valid && !ext.ready |=>
      ext.valid && $stable(ext.id) && $stable(ext.data) && $stable(ext.error)
  );

endmodule

`default_nettype wire

/* hdl/snitch_offload.sv */
// ------------------------------------------------------------
// Offload path top level. Routes core requests to the external
// accelerator or the SSR config unit, merges the responses.
// ------------------------------------------------------------
`default_nettype none

module snitch_offload import snitch_offload_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Core request
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  acc_target_e req_target_i,
  input  ssr_op_e     req_op_i,
  input  imm_t        req_imm_i,
  input  id_t         req_id_i,
  input  data_t       req_arga_i,
  input  data_t       req_argb_i,
  // External accelerator request
  output logic        ext_qvalid_o,
  input  logic        ext_qready_i,
  output id_t         ext_id_o,
  output data_t       ext_arga_o,
  output data_t       ext_argb_o,
  // External accelerator response
  input  logic        ext_pvalid_i,
  output logic        ext_pready_o,
  input  id_t         ext_pid_i,
  input  data_t       ext_pdata_i,
  input  logic        ext_perror_i,
  // Core response
  output logic        rsp_valid_o,
  input  logic        rsp_ready_i,
  output id_t         rsp_id_o,
  output data_t       rsp_data_o,
  output logic        rsp_error_o
);

  logic      ssr_qvalid;
  logic      ssr_qready;
  logic      ssr_write;
  cfg_word_t ssr_word;
  data_t     ssr_wdata;
  id_t       ssr_id;

  ssr_cfg_if i_ssr_cfg_if ();
  acc_rsp_if i_ssr_rsp_if ();
  acc_rsp_if i_ext_rsp_if ();

  // Request payload goes to the accelerator as is
  assign ext_id_o   = req_id_i;
  assign ext_arga_o = req_arga_i;
  assign ext_argb_o = req_argb_i;

  assign i_ext_rsp_if.valid = ext_pvalid_i;
  assign i_ext_rsp_if.id    = ext_pid_i;
  assign i_ext_rsp_if.data  = ext_pdata_i;
  assign i_ext_rsp_if.error = ext_perror_i;
  assign ext_pready_o       = i_ext_rsp_if.ready;

  offload_router i_offload_router (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_target_i (req_target_i),
    .req_op_i     (req_op_i),
    .req_imm_i    (req_imm_i),
    .req_id_i     (req_id_i),
    .req_arga_i   (req_arga_i),
    .req_argb_i   (req_argb_i),
    .ext_qvalid_o (ext_qvalid_o),
    .ext_qready_i (ext_qready_i),
    .ssr_qvalid_o (ssr_qvalid),
    .ssr_qready_i (ssr_qready),
    .ssr_write_o  (ssr_write),
    .ssr_word_o   (ssr_word),
    .ssr_wdata_o  (ssr_wdata),
    .ssr_id_o     (ssr_id)
  );

  ssr_cfg_fsm i_ssr_cfg_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (ssr_qvalid),
    .req_ready_o (ssr_qready),
    .req_write_i (ssr_write),
    .req_word_i  (ssr_word),
    .req_wdata_i (ssr_wdata),
    .req_id_i    (ssr_id),
    .cfg         (i_ssr_cfg_if.ctrl),
    .rsp         (i_ssr_rsp_if.src)
  );

  ssr_cfg_regs i_ssr_cfg_regs (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .cfg    (i_ssr_cfg_if.bank)
  );

  offload_rsp_arbiter i_offload_rsp_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ext         (i_ext_rsp_if.sink),
    .ssr         (i_ssr_rsp_if.sink),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_id_o    (rsp_id_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_error_o (rsp_error_o)
  );

endmodule

`default_nettype wire

/* verif/tb_snitch_offload.sv */
// ------------------------------------------------------------
// Table-driven testbench for the offload path. Models the
// external accelerator and the SSR register map, and checks
// every response that reaches the core side.
// ------------------------------------------------------------
`default_nettype none

module tb_snitch_offload import snitch_offload_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned max_wait = 200;

  typedef struct packed {
    acc_target_e target;
    ssr_op_e     op;
    imm_t        imm;
    id_t         id;
    data_t       arga;
    data_t       argb;
    id_t         exp_id;
    data_t       exp_data;
    logic        pair;
  } entry_t;

  logic clk_i, rst_ni, req_valid_i, req_ready_o, ext_qvalid_o, ext_qready_i;
  acc_target_e req_target_i;
  ssr_op_e req_op_i;
  imm_t req_imm_i;
  id_t req_id_i, ext_id_o, ext_pid_i, rsp_id_o;
  data_t req_arga_i, req_argb_i, ext_arga_o, ext_argb_o, ext_pdata_i, rsp_data_o;
  logic ext_pvalid_i, ext_pready_o, ext_perror_i, rsp_valid_o, rsp_ready_i, rsp_error_o;

  entry_t table_q[$];
  string name_q[$];
  data_t model_words [num_ssrs][num_ssr_regs];
  int id_errs = 0, data_errs = 0, bit_errs = 0, timeout_errs = 0;
  int cur_k = 0;
  logic hold_ready = 1'b0;

  snitch_offload i_snitch_offload (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // Random source and checks
  // ----------------------------------------------------------
  function automatic int unsigned rand_bits(inout logic [15:0] state, input int unsigned n);
    int unsigned v;
    v = 0;
    for (int unsigned i = 0; i < n; i++) begin
      // Galois form, taps 16 14 13 11
      state = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
      v = (v << 1) | 32'(state[0]);
    end
    return v;
  endfunction

  task automatic check_id(input string name, input id_t exp, input id_t act);
    if (exp !== act) begin
      $display("ERR %s: expected id %0h, actual %0h", name, exp, act);
      id_errs++;
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("ERR %s: expected data %08h, actual %08h", name, exp, act);
      data_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERR %s: expected %b, actual %b", name, exp, act);
      bit_errs++;
    end
  endtask

  // ----------------------------------------------------------
  // Register map model and stimulus table
  // ----------------------------------------------------------
  function automatic imm_t cfg_addr(input int unsigned ssr, input int unsigned r);
    return {r[6:0], ssr[4:0]};
  endfunction

  function automatic data_t fill_value(input imm_t addr, input logic [3:0] tag);
    return {addr, tag, ~addr, 4'h5};
  endfunction

  // Returns the old word, then applies the write if mapped
  function automatic data_t model_access(input imm_t addr, input logic write, input data_t wdata);
    int unsigned s;
    int unsigned r;
    data_t old;
    s = 32'(addr[4:0]);
    r = 32'(addr[11:5]);
    old = '0;
    if (s < num_ssrs && r < num_ssr_regs) begin
      old = model_words[s][r];
      if (write) model_words[s][r] = wdata;
    end
    return old;
  endfunction

  task automatic add_entry(input string name, input acc_target_e target, input ssr_op_e op,
                           input imm_t imm, input id_t id, input data_t arga,
                           input data_t argb, input logic pair);
    entry_t e;
    imm_t addr;
    logic write;
    e = '{target: target, op: op, imm: imm, id: id, arga: arga, argb: argb,
          exp_id: '0, exp_data: '0, pair: pair};
    if (target == TARGET_EXT) begin
      e.exp_id = id;
      e.exp_data = arga + 32'd1;
    end else begin
      addr = (op == SCFGRI || op == SCFGWI) ? imm : argb[11:0];
      write = (op == SCFGW || op == SCFGWI);
      e.exp_id = write ? '0 : id;
      e.exp_data = model_access(addr, write, arga);
    end
    table_q.push_back(e);
    name_q.push_back(name);
  endtask

  task automatic build_table();
    imm_t a;
    imm_t unmapped [4];
    unmapped = '{cfg_addr(2, 0), cfg_addr(31, 1), cfg_addr(0, 4), cfg_addr(1, 127)};
    foreach (model_words[s, r]) model_words[s][r] = '0;
    for (int unsigned s = 0; s < num_ssrs; s++) begin
      for (int unsigned r = 0; r < num_ssr_regs; r++) begin
        a = cfg_addr(s, r);
        add_entry($sformatf("reset read %0d.%0d", s, r), TARGET_SSR, SCFGR, '0,
                  id_t'(1 + 4 * s + r), '0, data_t'(a), 1'b0);
      end
    end
    for (int unsigned s = 0; s < num_ssrs; s++) begin
      for (int unsigned r = 0; r < num_ssr_regs; r++) begin
        a = cfg_addr(s, r);
        add_entry($sformatf("scfgw %0d.%0d", s, r), TARGET_SSR, SCFGW, '0, 5'd7,
                  fill_value(a, 4'h1), {20'hABCDE, a}, 1'b0);
        add_entry($sformatf("scfgr %0d.%0d", s, r), TARGET_SSR, SCFGR, '0,
                  id_t'(10 + 4 * s + r), '0, data_t'(a), 1'b0);
      end
    end
    // Immediate forms, argb points at an unmapped word
    for (int unsigned s = 0; s < num_ssrs; s++) begin
      for (int unsigned r = 0; r < num_ssr_regs; r++) begin
        a = cfg_addr(s, r);
        add_entry($sformatf("scfgwi %0d.%0d", s, r), TARGET_SSR, SCFGWI, a, 5'd3,
                  fill_value(a, 4'h2), 32'h0000_0FFF, 1'b0);
        add_entry($sformatf("scfgr after wi %0d.%0d", s, r), TARGET_SSR, SCFGR, '0,
                  5'd19, '0, data_t'(a), 1'b0);
        add_entry($sformatf("scfgri %0d.%0d", s, r), TARGET_SSR, SCFGRI, a, 5'd20,
                  '0, 32'h0000_0FFF, 1'b0);
      end
    end
    foreach (unmapped[i]) begin
      add_entry($sformatf("unmapped write %03h", unmapped[i]), TARGET_SSR, SCFGW, '0,
                5'd1, fill_value(unmapped[i], 4'h3), data_t'(unmapped[i]), 1'b0);
      add_entry($sformatf("unmapped read %03h", unmapped[i]), TARGET_SSR, SCFGR, '0,
                5'd2, '0, data_t'(unmapped[i]), 1'b0);
    end
    // Aliasing would have clobbered these
    add_entry("reread 0.0", TARGET_SSR, SCFGR, '0, 5'd4, '0, data_t'(cfg_addr(0, 0)), 1'b0);
    add_entry("reread 1.3", TARGET_SSR, SCFGR, '0, 5'd5, '0, data_t'(cfg_addr(1, 3)), 1'b0);
    add_entry("ext a", TARGET_EXT, SCFGR, '0, 5'd3, 32'h1234_5678, 32'h9ABC_DEF0, 1'b0);
    add_entry("ext b", TARGET_EXT, SCFGW, 12'hFFF, 5'd17, 32'hFFFF_FFFF, 32'h0, 1'b0);
    add_entry("ext c", TARGET_EXT, SCFGWI, '0, 5'd30, 32'h0000_00FF, 32'h5555_AAAA, 1'b0);
    add_entry("pair ext", TARGET_EXT, SCFGR, '0, 5'd9, 32'h7FFF_FFFF, 32'h1, 1'b1);
    add_entry("pair ssr read", TARGET_SSR, SCFGR, '0, 5'd21, '0, data_t'(cfg_addr(1, 3)), 1'b0);
    add_entry("pair ssr write", TARGET_SSR, SCFGWI, cfg_addr(0, 2), 5'd6, 32'hCAFE_0001, '0, 1'b1);
    add_entry("pair ext 2", TARGET_EXT, SCFGR, '0, 5'd12, 32'h0BAD_F00D, 32'h2, 1'b0);
  endtask

  // ----------------------------------------------------------
  // Transaction tasks
  // ----------------------------------------------------------
  task automatic send_request(input int k);
    int unsigned waited;
    logic done;
    cur_k = k;
    req_target_i <= table_q[k].target;
    req_op_i     <= table_q[k].op;
    req_imm_i    <= table_q[k].imm;
    req_id_i     <= table_q[k].id;
    req_arga_i   <= table_q[k].arga;
    req_argb_i   <= table_q[k].argb;
    req_valid_i  <= 1'b1;
    done = 1'b0;
    waited = 0;
    while (!done && waited < max_wait) begin
      @(posedge clk_i);
      waited++;
      if (req_ready_o) done = 1'b1;
    end
    req_valid_i <= 1'b0;
    if (!done) begin
      $display("Timeout: request %s was never accepted", name_q[k]);
      timeout_errs++;
    end
  endtask

  task automatic wait_response(output id_t id, output data_t data, output logic err,
                               output logic ok);
    int unsigned waited;
    ok = 1'b0;
    waited = 0;
    id = '0;
    data = '0;
    err = 1'b0;
    while (!ok && waited < max_wait) begin
      @(posedge clk_i);
      waited++;
      if (rsp_valid_o && rsp_ready_i) begin
        id = rsp_id_o;
        data = rsp_data_o;
        err = rsp_error_o;
        ok = 1'b1;
      end
    end
    if (!ok) begin
      $display("Timeout: no response arrived within %0d cycles", max_wait);
      timeout_errs++;
    end
  endtask

  task automatic check_response(input int k, input id_t id, input data_t data, input logic err);
    check_id(name_q[k], table_q[k].exp_id, id);
    check_data(name_q[k], table_q[k].exp_data, data);
    check_bit({name_q[k], " error"}, 1'b0, err);
  endtask

  // Both responses are held back until they are pending together
  task automatic run_pair(input int k);
    id_t rid;
    data_t rdata;
    logic rerr, ok, got_a, got_b;
    int unsigned waited;
    got_a = 1'b0;
    got_b = 1'b0;
    hold_ready <= 1'b1;
    send_request(k);
    send_request(k + 1);
    waited = 0;
    while (!ext_pvalid_i && waited < max_wait) begin
      @(posedge clk_i);
      waited++;
    end
    if (!ext_pvalid_i) begin
      $display("Timeout: external response for %s never became pending", name_q[k]);
      timeout_errs++;
    end
    check_bit({name_q[k], " both pending"}, 1'b1, rsp_valid_o);
    hold_ready <= 1'b0;
    for (int n = 0; n < 2; n++) begin
      wait_response(rid, rdata, rerr, ok);
      if (ok && !got_a && rid == table_q[k].exp_id) begin
        check_response(k, rid, rdata, rerr);
        got_a = 1'b1;
      end else if (ok) begin
        check_response(k + 1, rid, rdata, rerr);
        got_b = 1'b1;
      end
    end
    check_bit({name_q[k], " both delivered"}, 1'b1, got_a && got_b);
  endtask

  // ----------------------------------------------------------
  // External accelerator model and core ready
  // ----------------------------------------------------------
  initial begin : ext_model
    logic [15:0] lfsr;
    int unsigned delay, waited;
    int k;
    logic taken;
    id_t id;
    data_t arga;
    lfsr = 16'd22;
    ext_qready_i <= 1'b0;
    ext_pvalid_i <= 1'b0;
    ext_pid_i    <= '0;
    ext_pdata_i  <= '0;
    ext_perror_i <= 1'b0;
    forever begin
      @(posedge clk_i);
      if (ext_qvalid_o) begin
        // Table entry of the request now on offer
        k = cur_k;
        delay = rand_bits(lfsr, 2);
        repeat (delay) @(posedge clk_i);
        ext_qready_i <= 1'b1;
        @(posedge clk_i);
        check_id({name_q[k], " ext_id_o"}, table_q[k].id, ext_id_o);
        check_data({name_q[k], " ext_arga_o"}, table_q[k].arga, ext_arga_o);
        check_data({name_q[k], " ext_argb_o"}, table_q[k].argb, ext_argb_o);
        id = ext_id_o;
        arga = ext_arga_o;
        ext_qready_i <= 1'b0;
        delay = rand_bits(lfsr, 2);
        repeat (delay) @(posedge clk_i);
        ext_pvalid_i <= 1'b1;
        ext_pid_i    <= id;
        ext_pdata_i  <= arga + 32'd1;
        taken = 1'b0;
        waited = 0;
        while (!taken && waited < max_wait) begin
          @(posedge clk_i);
          waited++;
          if (ext_pready_o) taken = 1'b1;
        end
        ext_pvalid_i <= 1'b0;
        if (!taken) begin
          $display("Timeout: external response was never taken");
          timeout_errs++;
        end
      end
    end
  end

  initial begin : ready_driver
    logic [15:0] lfsr;
    lfsr = 16'd22;
    rsp_ready_i <= 1'b0;
    forever begin
      @(posedge clk_i);
      if (hold_ready) rsp_ready_i <= 1'b0;
      else rsp_ready_i <= rand_bits(lfsr, 1) == 1;
    end
  end

  initial begin : watchdog
    repeat (20000) @(posedge clk_i);
    $display("Watchdog expired before the stimulus table finished");
    $display("Regression failed");
    $finish;
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin : main
    id_t rid;
    data_t rdata;
    logic rerr, ok;
    int k;
    rst_ni <= 1'b1;
    req_valid_i <= 1'b0;
    req_target_i <= TARGET_EXT;
    req_op_i <= SCFGR;
    req_imm_i <= '0;
    req_id_i <= '0;
    req_arga_i <= '0;
    req_argb_i <= '0;
    build_table();
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (2) @(posedge clk_i);
    check_bit("rsp_valid_o after reset", 1'b0, rsp_valid_o);
    check_bit("ext_qvalid_o after reset", 1'b0, ext_qvalid_o);
    k = 0;
    while (k < table_q.size()) begin
      if (table_q[k].pair) begin
        run_pair(k);
        k += 2;
      end else begin
        send_request(k);
        wait_response(rid, rdata, rerr, ok);
        if (ok) check_response(k, rid, rdata, rerr);
        k++;
      end
    end
    repeat (2) @(posedge clk_i);
    check_bit("rsp_valid_o at end", 1'b0, rsp_valid_o);
    $display("Errors: id %0d, data %0d, bit %0d, timeout %0d",
             id_errs, data_errs, bit_errs, timeout_errs);
    if (id_errs + data_errs + bit_errs + timeout_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* snitch_offload.f */
hdl/snitch_offload_pkg.sv
hdl/ssr_cfg_if.sv
hdl/acc_rsp_if.sv
hdl/offload_router.sv
hdl/ssr_cfg_fsm.sv
hdl/ssr_cfg_regs.sv
hdl/offload_rsp_arbiter.sv
hdl/snitch_offload.sv
verif/tb_snitch_offload.sv

/* Makefile */
TOP := tb_snitch_offload

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f snitch_offload.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f snitch_offload.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
